// File: sim/apu_pulse_testdata.txt
# write addr data (hex) | quarter n | half n | run n | enable b
# expect_sample value | expect_active bit | count_high cycles expected_high_samples
enable 1
# index 5 loads a length of 4.
write 0 1f
write 2 10
write 3 28
run 2
expect_active 1
half 3
expect_active 1
half 1
expect_active 0
# halt keeps the count.
write 0 3f
write 3 28
run 2
half 6
expect_active 1
# constant volume 9 at 50 percent duty, checked inside step 1.
write 0 b9
write 2 40
write 3 08
run 72
expect_sample 9
# one full waveform at period 8 for each duty setting.
write 0 3f
write 2 08
write 3 08
run 2
count_high 72 9
write 0 7f
count_high 72 18
write 0 bf
count_high 72 36
write 0 ff
count_high 72 54
# a period below 8 mutes a live channel.
write 2 05
expect_active 1
count_high 48 0
# disable empties the length counter.
write 2 08
enable 0
expect_active 0
count_high 72 0
enable 1
# envelope restarts at 15 and drops every volume+1 quarter frames.
write 0 c1
write 2 ff
write 3 0f
run 2
quarter 1
expect_sample 15
quarter 2
expect_sample 14
quarter 28
expect_sample 0
quarter 2
expect_sample 0
# loop wraps the level back to 15.
write 0 e1
quarter 2
expect_sample 15

// File: sim/tb_apu_pulse_channel.sv
// tb_apu_pulse_channel: file-driven testbench for the pulse channel with checks and watchdog.
`default_nettype none

module tb_apu_pulse_channel;

	logic                       n_aclk;
	logic                       rst;
	logic                       wr;
	logic [apu_pkg::addr_w-1:0] addr;
	logic [apu_pkg::data_w-1:0] wdata;
	logic                       quarter_frame;
	logic                       half_frame;
	logic                       enable;
	apu_pkg::env_t              sample;
	logic                       length_active;

	string cmd_q[$];
	int    arg_a[$];
	int    arg_b[$];
	int    errors = 0;
	int    checks = 0;
	int    budget = 0;
	logic  budget_ready = 1'b0;

	apu_pulse_channel u_apu_pulse_channel (
		.n_aclk       (n_aclk),
		.rst          (rst),
		.wr           (wr),
		.addr         (addr),
		.wdata        (wdata),
		.quarter_frame(quarter_frame),
		.half_frame   (half_frame),
		.enable       (enable),
		.sample       (sample),
		.length_active(length_active)
	);

	always #50 n_aclk = ~n_aclk;

	task automatic check_value(input string what, input logic [31:0] got, input int expected);
		checks++;
		assert (got == expected) else begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic cpu_write(input int a, input int d);
		wr = 1'b1;
		addr = a[apu_pkg::addr_w-1:0];
		wdata = d[apu_pkg::data_w-1:0];
		@(negedge n_aclk);
		wr = 1'b0;
	endtask

	// each strobe is one cycle wide and followed by one idle cycle.
	task automatic pulse_frames(input logic is_half, input int n);
		repeat (n) begin
			quarter_frame = !is_half;
			half_frame = is_half;
			@(negedge n_aclk);
			quarter_frame = 1'b0;
			half_frame = 1'b0;
			@(negedge n_aclk);
		end
	endtask

	task automatic count_high(input int cycles, input int expected);
		int high;
		high = 0;
		repeat (cycles) begin
			@(negedge n_aclk);
			if (sample != '0) begin
				high++;
			end
		end
		check_value("high sample count", high, expected);
	endtask

	task automatic load_tests();
		int    fd;
		int    code;
		int    a;
		int    b;
		string word;
		string rest;
		fd = $fopen("sim/apu_pulse_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the test data file sim/apu_pulse_testdata.txt");
			return;
		end
		while ($fscanf(fd, "%s", word) == 1) begin
			a = 0;
			b = 0;
			if (word.substr(0, 0) == "#") begin
				code = $fgets(rest, fd);
				continue;
			end
			case (word)
				"write":      code = $fscanf(fd, "%h %h", a, b);
				"count_high": code = $fscanf(fd, "%d %d", a, b);
				default:      code = $fscanf(fd, "%d", a);
			endcase
			if (code < 1) begin
				errors++;
				$display("the test data has missing arguments after %s", word);
			end
			cmd_q.push_back(word);
			arg_a.push_back(a);
			arg_b.push_back(b);
		end
		$fclose(fd);
	endtask

	initial begin
		n_aclk = 1'b0;
		rst = 1'b1;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		quarter_frame = 1'b0;
		half_frame = 1'b0;
		enable = 1'b0;
		load_tests();
		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"run", "count_high": budget += arg_a[i];
				"quarter", "half":   budget += 2 * arg_a[i];
				default:             budget += 2;
			endcase
		end
		// reset length plus some slack.
		budget += 16 + 100;
		budget_ready = 1'b1;
		repeat (16) @(negedge n_aclk);
		rst = 1'b0;
		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"write":         cpu_write(arg_a[i], arg_b[i]);
				"quarter":       pulse_frames(1'b0, arg_a[i]);
				"half":          pulse_frames(1'b1, arg_a[i]);
				"run":           repeat (arg_a[i]) @(negedge n_aclk);
				"expect_sample": check_value("sample", sample, arg_a[i]);
				"expect_active": check_value("length_active", length_active, arg_a[i]);
				"count_high":    count_high(arg_a[i], arg_b[i]);
				"enable": begin
					enable = (arg_a[i] != 0);
					@(negedge n_aclk);
				end
				default: begin
					errors++;
					$display("the test data holds an unknown command %s", cmd_q[i]);
				end
			endcase
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		wait (budget_ready);
		repeat (budget) @(posedge n_aclk);
		$display("the run timed out after %0d cycles", budget);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/apu_down_counter.sv
// apu_down_counter: synchronous down counter with load, clear, step and zero flag.
`default_nettype none

module apu_down_counter #(
	parameter type count_t = apu_pkg::len_t
) (
	input  wire    n_aclk,
	input  wire    rst,
	input  wire    load,
	input  count_t d,
	input  wire    clear,
	input  wire    step,
	output count_t q,
	output logic   zero
);

	assign zero = (q == count_t'(0));

	// load beats clear, clear beats step.
	always_ff @(posedge n_aclk) begin
		if (rst) begin
			q <= count_t'(0);
		end else if (load) begin
			q <= d;
		end else if (clear) begin
			q <= count_t'(0);
		end else if (step && !zero) begin
			q <= count_t'(q - 1'b1);
		end
	end

	// the count only ever goes up through a load.
	a_no_rise: assert property (
		@(posedge n_aclk) disable iff (rst)
		!load |=> (q <= $past(q))
	);

endmodule

`default_nettype wire

// File: src/apu_envelope.sv
// apu_envelope: envelope divider, start flag and decay level.
`default_nettype none

module apu_envelope (
	input  wire           n_aclk,
	input  wire           rst,
	input  wire           quarter_frame,
	input  wire           restart,
	input  wire           loop,
	input  apu_pkg::env_t volume,
	output apu_pkg::env_t level
);

	logic          start_flag;
	apu_pkg::env_t decay;
	logic          div_load;
	logic          div_step;
	logic          div_zero;

	// the divider period is volume+1 quarter frames.
	assign div_load = quarter_frame && (start_flag || div_zero);
	assign div_step = quarter_frame && !start_flag;

	apu_down_counter #(
		.count_t(apu_pkg::env_t)
	) u_divider (
		.n_aclk(n_aclk),
		.rst   (rst),
		.load  (div_load),
		.d     (volume),
		.clear (1'b0),
		.step  (div_step),
		.q     (),
		.zero  (div_zero)
	);

	always_ff @(posedge n_aclk) begin
		if (rst) begin
			start_flag <= 1'b0;
		end else if (restart) begin
			start_flag <= 1'b1;
		end else if (quarter_frame) begin
			start_flag <= 1'b0;
		end
	end

	always_ff @(posedge n_aclk) begin
		if (rst) begin
			decay <= '0;
		end else if (quarter_frame) begin
			if (start_flag) begin
				decay <= '1;
			end else if (div_zero) begin
				if (decay != '0) begin
					decay <= decay - 1'b1;
				end else if (loop) begin
					decay <= '1;
				end
			end
		end
	end

	assign level = decay;

	// a pending start is consumed by the next quarter frame.
	a_start_taken: assert property (
		@(posedge n_aclk) disable iff (rst)
		(start_flag && quarter_frame && !restart) |=> (!start_flag && (level == '1))
	);

endmodule

`default_nettype wire

// File: src/apu_length_counter.sv
// apu_length_counter: length counter with table load, halt and enable.
`default_nettype none

module apu_length_counter (
	input  wire                              n_aclk,
	input  wire                              rst,
	input  wire                              load,
	input  wire [apu_pkg::len_index_w-1:0]   len_index,
	input  wire                              enable,
	input  wire                              half_frame,
	input  wire                              halt,
	output logic                             active
);

	apu_pkg::len_t count;
	apu_pkg::len_t reload;
	logic          cnt_load;
	logic          cnt_clear;
	logic          cnt_step;
	logic          cnt_zero;

	assign reload = apu_pkg::length_table[len_index];

	// a disabled channel ignores loads and is forced silent.
	assign cnt_load  = load && enable;
	assign cnt_clear = !enable;
	assign cnt_step  = half_frame && !halt;

	apu_down_counter #(
		.count_t(apu_pkg::len_t)
	) u_length (
		.n_aclk(n_aclk),
		.rst   (rst),
		.load  (cnt_load),
		.d     (reload),
		.clear (cnt_clear),
		.step  (cnt_step),
		.q     (count),
		.zero  (cnt_zero)
	);

	assign active = !cnt_zero;

	// enable low empties the counter on the next edge.
	a_disable_clears: assert property (
		@(posedge n_aclk) disable iff (rst)
		!enable |=> (count == '0)
	);

	// while halted the count holds unless reloaded or cleared.
	a_halt_holds: assert property (
		@(posedge n_aclk) disable iff (rst)
		(halt && enable && !load) |=> $stable(count)
	);

	// a load with enable high always brings the channel alive.
	a_load_active: assert property (
		@(posedge n_aclk) disable iff (rst)
		(load && enable) |=> active
	);

endmodule

`default_nettype wire

// File: src/apu_pkg.sv
// apu_pkg: register map, field widths, payload types, duty patterns and length lookup.
`default_nettype none

package apu_pkg;

	// cpu bus.
	localparam int addr_w = 2;
	localparam int data_w = 8;

	localparam logic [addr_w-1:0] reg_ctrl  = 2'd0;
	localparam logic [addr_w-1:0] reg_sweep = 2'd1;
	localparam logic [addr_w-1:0] reg_lo    = 2'd2;
	localparam logic [addr_w-1:0] reg_hi    = 2'd3;

	// register fields.
	localparam int duty_w      = 2;
	localparam int len_index_w = 5;

	typedef logic [10:0] timer_t;
	typedef logic [3:0]  env_t;
	typedef logic [7:0]  len_t;

	// periods below this are ultrasonic and get muted.
	localparam timer_t min_period = 11'd8;

	// one bit per sequencer step, step 0 in bit 0.
	localparam logic [7:0] duty_table [4] = '{
		8'b0000_0010,
		8'b0000_0110,
		8'b0001_1110,
		8'b1111_1001
	};

	// length counter reload values, indexed by the 5-bit field of register 3.
	localparam len_t length_table [32] = '{
		8'd10,  8'd254, 8'd20, 8'd2,
		8'd40,  8'd4,   8'd80, 8'd6,
		8'd160, 8'd8,   8'd60, 8'd10,
		8'd14,  8'd12,  8'd26, 8'd14,
		8'd12,  8'd16,  8'd24, 8'd18,
		8'd48,  8'd20,  8'd96, 8'd22,
		8'd192, 8'd24,  8'd72, 8'd26,
		8'd16,  8'd28,  8'd32, 8'd30
	};

endpackage

`default_nettype wire

// File: src/apu_pulse_channel.sv
// apu_pulse_channel: pulse channel top with registered 4-bit sample.
`default_nettype none

module apu_pulse_channel (
	input  wire                          n_aclk,
	input  wire                          rst,
	input  wire                          wr,
	input  wire [apu_pkg::addr_w-1:0]    addr,
	input  wire [apu_pkg::data_w-1:0]    wdata,
	input  wire                          quarter_frame,
	input  wire                          half_frame,
	input  wire                          enable,
	output apu_pkg::env_t                sample,
	output logic                         length_active
);

	logic [apu_pkg::duty_w-1:0]      duty;
	logic                            halt_loop;
	logic                            const_vol;
	apu_pkg::env_t                   volume;
	apu_pkg::timer_t                 period;
	logic [apu_pkg::len_index_w-1:0] len_index;
	logic                            hi_write;
	apu_pkg::env_t                   env_level;
	logic                            wave;
	logic                            voiced;

	apu_pulse_regs u_regs (
		.n_aclk   (n_aclk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.wdata    (wdata),
		.duty     (duty),
		.halt_loop(halt_loop),
		.const_vol(const_vol),
		.volume   (volume),
		.period   (period),
		.len_index(len_index),
		.hi_write (hi_write)
	);

	apu_envelope u_envelope (
		.n_aclk       (n_aclk),
		.rst          (rst),
		.quarter_frame(quarter_frame),
		.restart      (hi_write),
		.loop         (halt_loop),
		.volume       (volume),
		.level        (env_level)
	);

	apu_length_counter u_length (
		.n_aclk    (n_aclk),
		.rst       (rst),
		.load      (hi_write),
		.len_index (len_index),
		.enable    (enable),
		.half_frame(half_frame),
		.halt      (halt_loop),
		.active    (length_active)
	);

	apu_pulse_sequencer u_sequencer (
		.n_aclk (n_aclk),
		.rst    (rst),
		.period (period),
		.duty   (duty),
		.restart(hi_write),
		.wave   (wave)
	);

	// silent when the length ran out, the period is too short, or the duty bit is low.
	assign voiced = length_active && (period >= apu_pkg::min_period) && wave;

	always_ff @(posedge n_aclk) begin
		if (rst) begin
			sample <= '0;
		end else if (voiced) begin
			sample <= const_vol ? volume : env_level;
		end else begin
			sample <= '0;
		end
	end

endmodule

`default_nettype wire

// File: src/apu_pulse_regs.sv
// apu_pulse_regs: write-only pulse channel registers and register-3 write pulse.
`default_nettype none

module apu_pulse_regs (
	input  wire                                   n_aclk,
	input  wire                                   rst,
	input  wire                                   wr,
	input  wire  [apu_pkg::addr_w-1:0]            addr,
	input  wire  [apu_pkg::data_w-1:0]            wdata,
	output logic [apu_pkg::duty_w-1:0]            duty,
	output logic                                  halt_loop,
	output logic                                  const_vol,
	output apu_pkg::env_t                         volume,
	output apu_pkg::timer_t                       period,
	output logic [apu_pkg::len_index_w-1:0]       len_index,
	output logic                                  hi_write
);

	logic hi_hit;

	assign hi_hit = wr && (addr == apu_pkg::reg_hi);

	always_ff @(posedge n_aclk) begin
		if (rst) begin
			duty      <= '0;
			halt_loop <= 1'b0;
			const_vol <= 1'b0;
			volume    <= '0;
			period    <= '0;
			len_index <= '0;
			hi_write  <= 1'b0;
		end else begin
			// restarts the channel in the same cycle the new fields show up.
			hi_write <= hi_hit;
			if (wr) begin
				case (addr)
					apu_pkg::reg_ctrl: begin
						duty      <= wdata[7:6];
						halt_loop <= wdata[5];
						const_vol <= wdata[4];
						volume    <= wdata[3:0];
					end
					apu_pkg::reg_sweep: begin
						// no sweep unit on this channel, writes are dropped.
					end
					apu_pkg::reg_lo: begin
						period[7:0] <= wdata;
					end
					apu_pkg::reg_hi: begin
						len_index    <= wdata[7:3];
						period[10:8] <= wdata[2:0];
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: src/apu_pulse_sequencer.sv
// apu_pulse_sequencer: period timer and 8-step duty sequencer.
`default_nettype none

module apu_pulse_sequencer (
	input  wire                          n_aclk,
	input  wire                          rst,
	input  apu_pkg::timer_t              period,
	input  wire [apu_pkg::duty_w-1:0]    duty,
	input  wire                          restart,
	output logic                         wave
);

	logic       timer_zero;
	logic       timer_load;
	logic [2:0] seq_step;

	// counts period down to 0, so each step lasts period+1 cycles.
	assign timer_load = timer_zero || restart;

	apu_down_counter #(
		.count_t(apu_pkg::timer_t)
	) u_timer (
		.n_aclk(n_aclk),
		.rst   (rst),
		.load  (timer_load),
		.d     (period),
		.clear (1'b0),
		.step  (1'b1),
		.q     (),
		.zero  (timer_zero)
	);

	always_ff @(posedge n_aclk) begin
		if (rst) begin
			seq_step <= 3'd0;
		end else if (restart) begin
			seq_step <= 3'd0;
		end else if (timer_zero) begin
			// wraps at 8.
			seq_step <= seq_step + 3'd1;
		end
	end

	assign wave = apu_pkg::duty_table[duty][seq_step];

	// the step only moves on a timer expiry or a restart.
	a_step_on_zero: assert property (
		@(posedge n_aclk) disable iff (rst)
		(!timer_zero && !restart) |=> $stable(seq_step)
	);

endmodule

`default_nettype wire

// File: vlog.f
src/apu_pkg.sv
src/apu_down_counter.sv
src/apu_pulse_regs.sv
src/apu_envelope.sv
src/apu_length_counter.sv
src/apu_pulse_sequencer.sv
src/apu_pulse_channel.sv
sim/tb_apu_pulse_channel.sv
